//--- common/coreMemPkg.sv
package coreMemPkg;

    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 32;
    localparam int TAG_BITS  = 4;

    // access size in bytes is 1, 2 or 4
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd2,
        LEN_BAD  = 2'd3
    } memLen_t;

    // one load or store as it leaves the store/load buffer
    typedef struct packed {
        logic                 isStore;
        logic [ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0] data;
        memLen_t              len;
        logic [TAG_BITS-1:0]  tag;
    } memReq_t;

    // loads carry zero-extended data; stores only need the tag back
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic [TAG_BITS-1:0]  tag;
    } memResp_t;

endpackage

//--- common/ramBusPkg.sv
package ramBusPkg;

    // bit positions inside the wait vector
    localparam int PORT_FETCH = 0;
    localparam int PORT_DATA  = 1;

    localparam int RAM_CMD_ADDR_BITS = 32;

    // a set bit tells that port the controller will not take its request now
    typedef logic [1:0] portWait_t;

    // the RAM keeps only the low address bits it needs
    typedef struct packed {
        logic                         we;
        logic [RAM_CMD_ADDR_BITS-1:0] addr;
        logic [7:0]                   wdata;
    } ramCmd_t;

endpackage

//--- dataBuffer/dataRequestBuffer.sv
`timescale 1ns/1ps

module dataRequestBuffer
    import coreMemPkg::*;
    import ramBusPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,

    input  logic                 slbValid,
    input  memReq_t              slbReq,
    output logic                 slbReady,
    output logic                 slbDone,
    output memResp_t             slbResp,

    input  portWait_t            memWait,
    input  logic                 doneData,
    input  logic [DATA_BITS-1:0] doneWord,
    output logic                 dataEn,
    output memReq_t              dataReq
);

    logic    live;
    logic    occupied;
    memReq_t heldReq;

    // stays low for the first cycle after reset so the core sees ready only once we run
    always_ff @(posedge clk) begin
        if (rst) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    assign slbReady = rdy && live && !occupied;
    assign dataEn   = occupied && !memWait[PORT_DATA];
    assign dataReq  = heldReq;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            slbDone  <= 1'b0;
        end else begin
            // the controller only signals done while rdy is high
            slbDone <= doneData;
            if (rdy) begin
                if (doneData) begin
                    occupied <= 1'b0;
                end else if (slbValid) begin
                    occupied <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slbValid && slbReady) begin
            heldReq <= slbReq;
        end
        if (doneData) begin
            slbResp.data <= doneWord;
            slbResp.tag  <= heldReq.tag;
        end
    end

    // the core only strobes into an empty slot while rdy is high
    strobeWhenReady: assert property (@(posedge clk) disable iff (rst)
        slbValid |-> slbReady);

    lenIsLegal: assert property (@(posedge clk) disable iff (rst)
        slbValid |-> slbReq.len != LEN_BAD);

    // a done from the controller must belong to the request this slot still holds
    doneHitsHeldSlot: assert property (@(posedge clk) disable iff (rst)
        doneData |-> occupied ##1 !occupied);

endmodule

//--- src/instFetchPort.sv
`timescale 1ns/1ps

module instFetchPort
    import coreMemPkg::*;
    import ramBusPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,

    input  logic                 fetchValid,
    input  logic [ADDR_BITS-1:0] fetchPc,
    output logic                 fetchReady,
    output logic                 fetchDone,
    output logic [DATA_BITS-1:0] fetchInst,

    input  portWait_t            memWait,
    input  logic                 doneFetch,
    input  logic [DATA_BITS-1:0] doneWord,
    output logic                 fetchEn,
    output logic [ADDR_BITS-1:0] fetchAddr
);

    logic live;
    logic occupied;

    always_ff @(posedge clk) begin
        if (rst) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    assign fetchReady = rdy && live && !occupied;
    // fetches are always whole words, so only the pc is held
    assign fetchEn    = occupied && !memWait[PORT_FETCH];

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            fetchDone <= doneFetch;
            if (rdy) begin
                if (doneFetch) begin
                    occupied <= 1'b0;
                end else if (fetchValid) begin
                    occupied <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid && fetchReady) begin
            fetchAddr <= fetchPc;
        end
        if (doneFetch) begin
            fetchInst <= doneWord;
        end
    end

    strobeWhenReady: assert property (@(posedge clk) disable iff (rst)
        fetchValid |-> fetchReady);

endmodule

//--- memCtrl/memController.sv
`timescale 1ns/1ps

module memController
    import coreMemPkg::*;
    import ramBusPkg::*;
#(
    parameter int RAM_ADDR_BITS = 12
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,

    input  logic                 dataEn,
    input  memReq_t              dataReq,
    input  logic                 fetchEn,
    input  logic [ADDR_BITS-1:0] fetchAddr,
    output portWait_t            memWait,

    output logic                 ramValid,
    output ramCmd_t              ramCmd,
    input  logic [7:0]           ramRdata,

    output logic                 doneData,
    output logic                 doneFetch,
    output logic [DATA_BITS-1:0] doneWord
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        XFER  = 2'd1,
        DRAIN = 2'd2,
        DONE  = 2'd3
    } ctrlState_t;

    ctrlState_t           state;
    logic                 servingData;
    logic                 isStore;
    logic [ADDR_BITS-1:0] baseAddr;
    logic [DATA_BITS-1:0] storeData;
    logic [1:0]           lastIdx;
    logic [1:0]           byteIdx;
    logic                 readPending;
    logic [1:0]           readLane;
    logic [DATA_BITS-1:0] word;
    logic [ADDR_BITS-1:0] byteAddr;
    logic                 lastByte;

    function automatic logic [1:0] lenLastIdx(memLen_t len);
        case (len)
            LEN_BYTE: return 2'd0;
            LEN_HALF: return 2'd1;
            default:  return 2'd3;
        endcase
    endfunction

    // data wins in idle, so a fetch is only ever accepted when dataEn is already low
    assign memWait[PORT_DATA]  = state != IDLE;
    assign memWait[PORT_FETCH] = state != IDLE || dataEn;

    assign byteAddr = baseAddr + ADDR_BITS'(byteIdx);
    assign lastByte = byteIdx == lastIdx;

    // bytes go out lowest address first and wrap inside the RAM
    assign ramValid     = state == XFER;
    assign ramCmd.we    = isStore;
    assign ramCmd.addr  = RAM_CMD_ADDR_BITS'(byteAddr[RAM_ADDR_BITS-1:0]);
    assign ramCmd.wdata = storeData[byteIdx*8 +: 8];

    assign doneData  = state == DONE && rdy && servingData;
    assign doneFetch = state == DONE && rdy && !servingData;
    assign doneWord  = word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            readPending <= 1'b0;
        end else begin
            readPending <= state == XFER && !isStore;
            case (state)
                IDLE: begin
                    if (dataEn || fetchEn) begin
                        state <= XFER;
                    end
                end
                XFER: begin
                    if (lastByte) begin
                        state <= isStore ? DONE : DRAIN;
                    end
                end
                DRAIN: state <= DONE;
                // hold the done until the core side is running again
                DONE: begin
                    if (rdy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        readLane <= byteIdx;
        if (state == IDLE) begin
            byteIdx <= 2'd0;
            // the word starts cleared, which gives the zero fill above len
            word    <= '0;
            if (dataEn) begin
                servingData <= 1'b1;
                isStore     <= dataReq.isStore;
                baseAddr    <= dataReq.addr;
                storeData   <= dataReq.data;
                lastIdx     <= lenLastIdx(dataReq.len);
            end else begin
                servingData <= 1'b0;
                isStore     <= 1'b0;
                baseAddr    <= fetchAddr;
                storeData   <= '0;
                lastIdx     <= lenLastIdx(LEN_WORD);
            end
        end else begin
            if (state == XFER) begin
                byteIdx <= byteIdx + 2'd1;
            end
            if (readPending) begin
                word[readLane*8 +: 8] <= ramRdata;
            end
        end
    end

    // only one access is in flight, so no port may present a request until idle
    portsHeldWhileBusy: assert property (@(posedge clk) disable iff (rst)
        state != IDLE |-> !dataEn && !fetchEn);

endmodule

//--- memCtrl/byteRam.sv
`timescale 1ns/1ps

module byteRam
    import ramBusPkg::*;
#(
    parameter int RAM_ADDR_BITS = 12
) (
    input  logic       clk,
    input  logic       ramValid,
    input  ramCmd_t    ramCmd,
    output logic [7:0] ramRdata
);

    localparam int DEPTH = 2 ** RAM_ADDR_BITS;

    logic [7:0]               mem [DEPTH];
    logic [RAM_ADDR_BITS-1:0] idx;

    // upper address bits are dropped, so the address wraps at the depth
    assign idx = ramCmd.addr[RAM_ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (ramValid) begin
            if (ramCmd.we) begin
                mem[idx] <= ramCmd.wdata;
            end else begin
                ramRdata <= mem[idx];
            end
        end
    end

endmodule

//--- src/memAccessUnit.sv
`timescale 1ns/1ps

module memAccessUnit
    import coreMemPkg::*;
    import ramBusPkg::*;
#(
    parameter int RAM_ADDR_BITS = 12
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,

    input  logic                 slbValid,
    input  memReq_t              slbReq,
    output logic                 slbReady,
    output logic                 slbDone,
    output memResp_t             slbResp,

    input  logic                 fetchValid,
    input  logic [ADDR_BITS-1:0] fetchPc,
    output logic                 fetchReady,
    output logic                 fetchDone,
    output logic [DATA_BITS-1:0] fetchInst
);

    portWait_t            memWait;
    logic                 dataEn;
    memReq_t              dataReq;
    logic                 fetchEn;
    logic [ADDR_BITS-1:0] fetchAddr;
    logic                 doneData;
    logic                 doneFetch;
    logic [DATA_BITS-1:0] doneWord;
    logic                 ramValid;
    ramCmd_t              ramCmd;
    logic [7:0]           ramRdata;

    dataRequestBuffer u_dataRequestBuffer (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .slbValid (slbValid),
        .slbReq   (slbReq),
        .slbReady (slbReady),
        .slbDone  (slbDone),
        .slbResp  (slbResp),
        .memWait  (memWait),
        .doneData (doneData),
        .doneWord (doneWord),
        .dataEn   (dataEn),
        .dataReq  (dataReq)
    );

    instFetchPort u_instFetchPort (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchReady (fetchReady),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .memWait    (memWait),
        .doneFetch  (doneFetch),
        .doneWord   (doneWord),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr)
    );

    memController #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) u_memController (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .dataEn    (dataEn),
        .dataReq   (dataReq),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .memWait   (memWait),
        .ramValid  (ramValid),
        .ramCmd    (ramCmd),
        .ramRdata  (ramRdata),
        .doneData  (doneData),
        .doneFetch (doneFetch),
        .doneWord  (doneWord)
    );

    byteRam #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) u_byteRam (
        .clk      (clk),
        .ramValid (ramValid),
        .ramCmd   (ramCmd),
        .ramRdata (ramRdata)
    );

endmodule

//--- test/memAccessUnitTb.sv
`timescale 1ns/1ps

module memAccessUnitTb
    import coreMemPkg::*;
();

    localparam int          RAM_ADDR_BITS = 12;
    localparam int          WAIT_LIMIT    = 50;
    localparam logic [31:0] ADDR_MASK     = 2 ** RAM_ADDR_BITS - 4;
    localparam logic [31:0] RAND_SEED     = 32'h6b9c07ae;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 slbValid;
    memReq_t              slbReq;
    logic                 slbReady;
    logic                 slbDone;
    memResp_t             slbResp;
    logic                 fetchValid;
    logic [ADDR_BITS-1:0] fetchPc;
    logic                 fetchReady;
    logic                 fetchDone;
    logic [DATA_BITS-1:0] fetchInst;

    // reference bytes, updated by every store the testbench issues
    logic [7:0] refMem [2**RAM_ADDR_BITS];
    int         errorCount;
    int         testStart;
    int         testCount;

    memAccessUnit #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_memAccessUnit (.*);

    always #4 clk = ~clk;

    // an access covers 1 << len bytes, little-endian, wrapping at the RAM depth
    function automatic logic [31:0] modelRead(logic [31:0] addr, memLen_t len);
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < (1 << len); i++) begin
            word[i*8 +: 8] = refMem[RAM_ADDR_BITS'(addr + i)];
        end
        return word;
    endfunction

    function automatic void modelWrite(logic [31:0] addr, logic [31:0] data, memLen_t len);
        for (int i = 0; i < (1 << len); i++) begin
            refMem[RAM_ADDR_BITS'(addr + i)] = data[i*8 +: 8];
        end
    endfunction

    function automatic logic portFlag(logic onFetch, logic forDone);
        if (forDone)
            return onFetch ? fetchDone : slbDone;
        return onFetch ? fetchReady : slbReady;
    endfunction

    task automatic checkValue(string testName, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %08h actual %08h", testName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic waitForFlag(string testName, logic onFetch, logic forDone, output logic ok);
        int cycles;
        cycles = 0;
        ok     = portFlag(onFetch, forDone);
        while (!ok && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            ok = portFlag(onFetch, forDone);
        end
        if (!ok) begin
            $display("%s: timed out waiting for the %s port to signal %s", testName,
                     onFetch ? "fetch" : "data", forDone ? "done" : "ready");
            errorCount++;
        end
    endtask

    // one load or store on the data port; a nonzero stall holds rdy low after the strobe
    task automatic dataAccess(string testName, logic isStore, logic [31:0] addr,
                              memLen_t len, int stall);
        logic ok;
        waitForFlag(testName, 1'b0, 1'b0, ok);
        slbReq   = {isStore, addr, $urandom, len, 4'($urandom)};
        slbValid = ok;
        @(posedge clk);
        #1;
        slbValid = 1'b0;
        if (ok && isStore)
            modelWrite(addr, slbReq.data, len);
        if (stall > 0)
            rdy = 1'b0;
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            #1;
            if (slbDone) begin
                $display("%s: slbDone appeared while rdy was low", testName);
                errorCount++;
            end
        end
        rdy = 1'b1;
        if (ok)
            waitForFlag(testName, 1'b0, 1'b1, ok);
        if (!isStore)
            checkValue(testName, modelRead(addr, len), slbResp.data);
        checkValue(testName, slbReq.tag, slbResp.tag);
    endtask

    task automatic fetchAccess(string testName, logic [31:0] pc);
        logic ok;
        waitForFlag(testName, 1'b1, 1'b0, ok);
        fetchPc    = pc;
        fetchValid = ok;
        @(posedge clk);
        #1;
        fetchValid = 1'b0;
        if (ok)
            waitForFlag(testName, 1'b1, 1'b1, ok);
        checkValue(testName, modelRead(pc, LEN_WORD), fetchInst);
    endtask

    task automatic reportTest(string testName);
        $display("%s finished with %0d failing checks", testName, errorCount - testStart);
        testCount++;
        testStart = errorCount;
    endtask

    task automatic wordStoreLoad();
        logic [31:0] addrs [4];
        for (int i = 0; i < 4; i++) begin
            addrs[i] = $urandom & ADDR_MASK;
            dataAccess("wordStoreLoad", 1'b1, addrs[i], LEN_WORD, 0);
        end
        for (int i = 0; i < 4; i++) begin
            dataAccess("wordStoreLoad", 1'b0, addrs[i], LEN_WORD, 0);
        end
        reportTest("wordStoreLoad");
    endtask

    task automatic lengthMix();
        logic [31:0] base;
        base = $urandom & ADDR_MASK;
        dataAccess("lengthMix", 1'b1, base, LEN_WORD, 0);
        dataAccess("lengthMix", 1'b1, base + 1, LEN_BYTE, 0);
        dataAccess("lengthMix", 1'b1, base + 2, LEN_HALF, 0);
        dataAccess("lengthMix", 1'b0, base + 1, LEN_BYTE, 0);
        dataAccess("lengthMix", 1'b0, base + 3, LEN_BYTE, 0);
        dataAccess("lengthMix", 1'b0, base + 2, LEN_HALF, 0);
        dataAccess("lengthMix", 1'b0, base, LEN_HALF, 0);
        dataAccess("lengthMix", 1'b0, base, LEN_WORD, 0);
        reportTest("lengthMix");
    endtask

    task automatic fetchAfterStore();
        logic [31:0] base;
        base = $urandom & ADDR_MASK;
        dataAccess("fetchAfterStore", 1'b1, base, LEN_WORD, 0);
        fetchAccess("fetchAfterStore", base);
        reportTest("fetchAfterStore");
    endtask

    task automatic concurrentPorts();
        logic [31:0] loadAddr;
        logic [31:0] pc;
        logic        dataOk;
        logic        fetchOk;
        int          dataDones;
        int          fetchDones;
        loadAddr = $urandom & ADDR_MASK;
        pc       = $urandom & ADDR_MASK;
        dataAccess("concurrentPorts", 1'b1, loadAddr, LEN_WORD, 0);
        dataAccess("concurrentPorts", 1'b1, pc, LEN_WORD, 0);
        // an empty slot stays ready while the other port is awaited
        waitForFlag("concurrentPorts", 1'b0, 1'b0, dataOk);
        waitForFlag("concurrentPorts", 1'b1, 1'b0, fetchOk);
        slbReq     = {1'b0, loadAddr, 32'h0, LEN_WORD, 4'($urandom)};
        fetchPc    = pc;
        slbValid   = dataOk;
        fetchValid = fetchOk;
        @(posedge clk);
        #1;
        slbValid   = 1'b0;
        fetchValid = 1'b0;
        dataDones  = 0;
        fetchDones = 0;
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            if ((dataDones == 0 && !slbDone && slbReady) ||
                (fetchDones == 0 && !fetchDone && fetchReady)) begin
                $display("concurrentPorts: a port showed ready while its slot was occupied");
                errorCount++;
            end
            if (slbDone) begin
                dataDones++;
                checkValue("concurrentPorts", modelRead(loadAddr, LEN_WORD), slbResp.data);
                checkValue("concurrentPorts", slbReq.tag, slbResp.tag);
            end
            if (fetchDone) begin
                fetchDones++;
                checkValue("concurrentPorts", modelRead(pc, LEN_WORD), fetchInst);
            end
            @(posedge clk);
            #1;
        end
        if (dataDones != 1 || fetchDones != 1) begin
            $display("concurrentPorts: saw %0d data dones and %0d fetch dones instead of one each",
                     dataDones, fetchDones);
            errorCount++;
        end
        reportTest("concurrentPorts");
    endtask

    task automatic rdyStall();
        logic [31:0] base;
        base = $urandom & ADDR_MASK;
        dataAccess("rdyStall", 1'b1, base, LEN_WORD, 0);
        dataAccess("rdyStall", 1'b0, base, LEN_WORD, 12);
        reportTest("rdyStall");
    endtask

    task automatic addressWrap();
        logic [31:0] base;
        logic [31:0] high;
        base = $urandom & ADDR_MASK;
        // at least one bit above the RAM size is set
        high = base | ($urandom << RAM_ADDR_BITS) | (32'h1 << RAM_ADDR_BITS);
        dataAccess("addressWrap", 1'b1, high, LEN_WORD, 0);
        dataAccess("addressWrap", 1'b0, base, LEN_WORD, 0);
        reportTest("addressWrap");
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        clk        = 1'b0;
        rst        = 1'b1;
        rdy        = 1'b1;
        slbValid   = 1'b0;
        slbReq     = '0;
        fetchValid = 1'b0;
        fetchPc    = '0;
        errorCount = 0;
        testStart  = 0;
        testCount  = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        wordStoreLoad();
        lengthMix();
        fetchAfterStore();
        concurrentPorts();
        rdyStall();
        addressWrap();
        $display("%0d tests run, %0d failing checks in total", testCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- memAccessUnit.f
common/coreMemPkg.sv
common/ramBusPkg.sv
dataBuffer/dataRequestBuffer.sv
src/instFetchPort.sv
memCtrl/memController.sv
memCtrl/byteRam.sv
src/memAccessUnit.sv
test/memAccessUnitTb.sv
